// File: all.f
+incdir+hdl
hdl/core_pkg.sv
hdl/register_file.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/result_stage.sv
hdl/riscv_core.sv
sim/core_checker.sv
sim/core_tb.sv

// File: hdl/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// --------------------
// Datapath sizing
// --------------------

// Data and address width
`define CORE_XLEN 32

// Architectural registers, x0 included
`define CORE_REG_COUNT 32

// --------------------
// Fixed values
// --------------------

// First fetch address after reset
`define CORE_RESET_ADDRESS 32'h0000_0000

// ADDI x0, x0, 0 used as the pipeline bubble
`define CORE_NOP 32'h0000_0013

`endif

// File: hdl/core_pkg.sv
`include "core_macros.svh"

package core_pkg;

    // RV32I major opcodes kept by this core
    typedef enum logic [6:0] {
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    // --------------------
    // Instruction layouts
    // --------------------

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fields;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fields;
        // Branches use this layout too
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_fields;
        // JAL uses this layout too
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fields;
    } instr_u;

    // --------------------
    // Stage payloads
    // --------------------

    typedef struct packed {
        logic                  valid;
        logic [`CORE_XLEN-1:0] pc;
        instr_u                instr;
    } fetch_to_decode_t;

    typedef struct packed {
        logic                               valid;
        opcode_e                            opcode;
        logic [2:0]                         funct3;
        alu_op_e                            alu_op;
        logic                               use_imm;
        logic [`CORE_XLEN-1:0]              pc;
        logic [`CORE_XLEN-1:0]              rs1_value;
        logic [`CORE_XLEN-1:0]              rs2_value;
        logic [`CORE_XLEN-1:0]              immediate;
        logic [$clog2(`CORE_REG_COUNT)-1:0] rd;
        logic                               reg_write;
    } decode_to_execute_t;

    typedef struct packed {
        logic                               valid;
        logic                               is_load;
        logic                               is_store;
        logic [`CORE_XLEN-1:0]              result;
        logic [`CORE_XLEN-1:0]              address;
        logic [`CORE_XLEN-1:0]              store_data;
        logic [$clog2(`CORE_REG_COUNT)-1:0] rd;
        logic                               reg_write;
    } execute_to_result_t;

    // ready is low while the value is still a pending load
    typedef struct packed {
        logic                               enable;
        logic [$clog2(`CORE_REG_COUNT)-1:0] index;
        logic [`CORE_XLEN-1:0]              data;
        logic                               ready;
    } reg_write_t;

    typedef struct packed {
        logic                  taken;
        logic [`CORE_XLEN-1:0] target;
    } redirect_t;

endpackage

// File: hdl/decode_stage.sv
`include "core_macros.svh"

module decode_stage
(
    input  logic                          clk,
    input  logic                          reset,
    input  core_pkg::fetch_to_decode_t    from_fetch,
    input  core_pkg::redirect_t           redirect,
    input  core_pkg::reg_write_t          execute_write,
    input  core_pkg::reg_write_t          memory_write,
    input  core_pkg::reg_write_t          writeback_write,
    output logic                          stall,
    output core_pkg::decode_to_execute_t  to_execute
);

    localparam int index_width = $clog2(`CORE_REG_COUNT);

    core_pkg::instr_u      instr;
    core_pkg::opcode_e     opcode;
    core_pkg::alu_op_e     funct_alu;
    core_pkg::alu_op_e     alu_op;
    logic                  rs1_used;
    logic                  rs2_used;
    logic                  writes_rd;
    logic                  use_imm;
    logic [`CORE_XLEN-1:0] immediate;
    logic [`CORE_XLEN-1:0] file_data_1;
    logic [`CORE_XLEN-1:0] file_data_2;
    logic [`CORE_XLEN-1:0] rs1_value;
    logic [`CORE_XLEN-1:0] rs2_value;

    assign instr  = from_fetch.instr;
    assign opcode = core_pkg::opcode_e'(instr.r_fields.opcode);

    // --------------------
    // Field decoding
    // --------------------

    // funct7[5] selects SUB only for OP, and SRA for both OP and OP-IMM
    always_comb
    begin
        case (instr.r_fields.funct3)
            3'b000:
                funct_alu = (opcode == core_pkg::opc_op && instr.r_fields.funct7[5]) ?
                            core_pkg::alu_sub : core_pkg::alu_add;
            3'b001: funct_alu = core_pkg::alu_sll;
            3'b010: funct_alu = core_pkg::alu_slt;
            3'b011: funct_alu = core_pkg::alu_sltu;
            3'b100: funct_alu = core_pkg::alu_xor;
            3'b101:
                funct_alu = instr.r_fields.funct7[5] ? core_pkg::alu_sra : core_pkg::alu_srl;
            3'b110: funct_alu = core_pkg::alu_or;
            default: funct_alu = core_pkg::alu_and;
        endcase
    end

    always_comb
    begin
        rs1_used  = 1'b0;
        rs2_used  = 1'b0;
        writes_rd = 1'b0;
        use_imm   = 1'b0;
        alu_op    = core_pkg::alu_add;
        // I format by default
        immediate = {{20{instr.i_fields.imm[11]}}, instr.i_fields.imm};
        case (opcode)
            core_pkg::opc_op:
            begin
                rs1_used  = 1'b1;
                rs2_used  = 1'b1;
                writes_rd = 1'b1;
                alu_op    = funct_alu;
            end
            core_pkg::opc_op_imm:
            begin
                rs1_used  = 1'b1;
                writes_rd = 1'b1;
                use_imm   = 1'b1;
                alu_op    = funct_alu;
            end
            core_pkg::opc_lui, core_pkg::opc_auipc:
            begin
                writes_rd = 1'b1;
                use_imm   = 1'b1;
                alu_op    = (opcode == core_pkg::opc_lui) ? core_pkg::alu_pass_b : core_pkg::alu_add;
                immediate = {instr.u_fields.imm, 12'b0};
            end
            core_pkg::opc_jal:
            begin
                writes_rd = 1'b1;
                immediate = {{11{instr.u_fields.imm[19]}}, instr.u_fields.imm[19],
                             instr.u_fields.imm[7:0], instr.u_fields.imm[8],
                             instr.u_fields.imm[18:9], 1'b0};
            end
            core_pkg::opc_jalr, core_pkg::opc_load:
            begin
                rs1_used  = 1'b1;
                writes_rd = 1'b1;
                use_imm   = 1'b1;
            end
            core_pkg::opc_branch:
            begin
                rs1_used  = 1'b1;
                rs2_used  = 1'b1;
                immediate = {{19{instr.s_fields.imm_hi[6]}}, instr.s_fields.imm_hi[6],
                             instr.s_fields.imm_lo[0], instr.s_fields.imm_hi[5:0],
                             instr.s_fields.imm_lo[4:1], 1'b0};
            end
            core_pkg::opc_store:
            begin
                rs1_used  = 1'b1;
                rs2_used  = 1'b1;
                use_imm   = 1'b1;
                immediate = {{20{instr.s_fields.imm_hi[6]}}, instr.s_fields.imm_hi,
                             instr.s_fields.imm_lo};
            end
            default:
            begin
                writes_rd = 1'b0;
            end
        endcase
    end

    register_file register_file
    (
        .clk          (clk),
        .reset        (reset),
        .read_index_1 (instr.r_fields.rs1),
        .read_index_2 (instr.r_fields.rs2),
        .read_data_1  (file_data_1),
        .read_data_2  (file_data_2),
        .write        (writeback_write)
    );

    // --------------------
    // Forwarding and hazards
    // --------------------

    // Nearest producer wins; x0 never matches since writes to it are never enabled
    function automatic logic [`CORE_XLEN-1:0] forward
    (
        input logic [index_width-1:0] index,
        input logic [`CORE_XLEN-1:0]  file_value,
        input core_pkg::reg_write_t   ex_src,
        input core_pkg::reg_write_t   mem_src,
        input core_pkg::reg_write_t   wb_src
    );
        if (ex_src.enable && ex_src.index == index)
            return ex_src.data;
        if (mem_src.enable && mem_src.index == index)
            return mem_src.data;
        if (wb_src.enable && wb_src.index == index)
            return wb_src.data;
        return file_value;
    endfunction

    assign rs1_value = forward(instr.r_fields.rs1, file_data_1,
                               execute_write, memory_write, writeback_write);
    assign rs2_value = forward(instr.r_fields.rs2, file_data_2,
                               execute_write, memory_write, writeback_write);

    // A load still in execute has no data yet
    assign stall = from_fetch.valid && execute_write.enable && !execute_write.ready &&
                   ((rs1_used && execute_write.index == instr.r_fields.rs1) ||
                    (rs2_used && execute_write.index == instr.r_fields.rs2));

    always_ff @(posedge clk)
    begin
        if (reset)
            to_execute.valid <= 1'b0;
        else
            to_execute.valid <= from_fetch.valid && !stall && !redirect.taken;
        to_execute.opcode    <= opcode;
        to_execute.funct3    <= instr.r_fields.funct3;
        to_execute.alu_op    <= alu_op;
        to_execute.use_imm   <= use_imm;
        to_execute.pc        <= from_fetch.pc;
        to_execute.rs1_value <= rs1_value;
        to_execute.rs2_value <= rs2_value;
        to_execute.immediate <= immediate;
        to_execute.rd        <= instr.r_fields.rd;
        to_execute.reg_write <= writes_rd && (instr.r_fields.rd != '0);
    end

endmodule

// File: hdl/execute_stage.sv
`include "core_macros.svh"

module execute_stage
(
    input  logic                          clk,
    input  logic                          reset,
    input  core_pkg::decode_to_execute_t  from_decode,
    output core_pkg::redirect_t           redirect,
    output core_pkg::reg_write_t          execute_write,
    output core_pkg::execute_to_result_t  to_result
);

    logic [`CORE_XLEN-1:0] operand_a;
    logic [`CORE_XLEN-1:0] operand_b;
    logic [`CORE_XLEN-1:0] alu_result;
    logic [`CORE_XLEN-1:0] link;
    logic [`CORE_XLEN-1:0] result;
    logic [`CORE_XLEN-1:0] address;
    logic                  is_jal;
    logic                  is_jalr;
    logic                  is_branch;
    logic                  is_load;
    logic                  branch_taken;

    assign is_jal    = from_decode.opcode == core_pkg::opc_jal;
    assign is_jalr   = from_decode.opcode == core_pkg::opc_jalr;
    assign is_branch = from_decode.opcode == core_pkg::opc_branch;
    assign is_load   = from_decode.opcode == core_pkg::opc_load;

    // --------------------
    // ALU
    // --------------------

    assign operand_a = (from_decode.opcode == core_pkg::opc_auipc) ?
                       from_decode.pc : from_decode.rs1_value;
    assign operand_b = from_decode.use_imm ? from_decode.immediate : from_decode.rs2_value;

    always_comb
    begin
        case (from_decode.alu_op)
            core_pkg::alu_sub:    alu_result = operand_a - operand_b;
            core_pkg::alu_sll:    alu_result = operand_a << operand_b[4:0];
            core_pkg::alu_slt:    alu_result = {31'b0, $signed(operand_a) < $signed(operand_b)};
            core_pkg::alu_sltu:   alu_result = {31'b0, operand_a < operand_b};
            core_pkg::alu_xor:    alu_result = operand_a ^ operand_b;
            core_pkg::alu_srl:    alu_result = operand_a >> operand_b[4:0];
            core_pkg::alu_sra:    alu_result = $signed(operand_a) >>> operand_b[4:0];
            core_pkg::alu_or:     alu_result = operand_a | operand_b;
            core_pkg::alu_and:    alu_result = operand_a & operand_b;
            core_pkg::alu_pass_b: alu_result = operand_b;
            default:              alu_result = operand_a + operand_b;
        endcase
    end

    // Jumps write the return address instead of the ALU value
    assign link   = from_decode.pc + `CORE_XLEN'd4;
    assign result = (is_jal || is_jalr) ? link : alu_result;

    // --------------------
    // Branch and target
    // --------------------

    always_comb
    begin
        case (from_decode.funct3)
            3'b000:  branch_taken = from_decode.rs1_value == from_decode.rs2_value;
            3'b001:  branch_taken = from_decode.rs1_value != from_decode.rs2_value;
            3'b100:  branch_taken = $signed(from_decode.rs1_value) < $signed(from_decode.rs2_value);
            3'b101:  branch_taken = $signed(from_decode.rs1_value) >= $signed(from_decode.rs2_value);
            3'b110:  branch_taken = from_decode.rs1_value < from_decode.rs2_value;
            3'b111:  branch_taken = from_decode.rs1_value >= from_decode.rs2_value;
            default: branch_taken = 1'b0;
        endcase
    end

    // Shared by loads, stores and JALR
    assign address = from_decode.rs1_value + from_decode.immediate;

    assign redirect.taken  = from_decode.valid && (is_jal || is_jalr || (is_branch && branch_taken));
    assign redirect.target = is_jalr ? {address[`CORE_XLEN-1:1], 1'b0} :
                                       from_decode.pc + from_decode.immediate;

    assign execute_write.enable = from_decode.valid && from_decode.reg_write;
    assign execute_write.index  = from_decode.rd;
    assign execute_write.data   = result;
    assign execute_write.ready  = !is_load;

    always_ff @(posedge clk)
    begin
        if (reset)
            to_result.valid <= 1'b0;
        else
            to_result.valid <= from_decode.valid;
        to_result.is_load    <= is_load;
        to_result.is_store   <= from_decode.opcode == core_pkg::opc_store;
        to_result.result     <= result;
        to_result.address    <= address;
        to_result.store_data <= from_decode.rs2_value;
        to_result.rd         <= from_decode.rd;
        to_result.reg_write  <= from_decode.reg_write;
    end

endmodule

// File: hdl/fetch_stage.sv
`include "core_macros.svh"

module fetch_stage
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        stall,
    input  core_pkg::redirect_t         redirect,
    output logic                        imem_enable,
    output logic [`CORE_XLEN-1:0]       imem_address,
    input  logic [`CORE_XLEN-1:0]       imem_data,
    output core_pkg::fetch_to_decode_t  to_decode
);

    logic [`CORE_XLEN-1:0] pc;

    // Redirect wins over stall, the stalled instruction is flushed anyway
    always_ff @(posedge clk)
    begin
        if (reset)
            pc <= `CORE_RESET_ADDRESS;
        else if (redirect.taken)
            pc <= redirect.target;
        else if (!stall)
            pc <= pc + `CORE_XLEN'd4;
    end

    // Fetch consumes a word in every cycle decode can take it
    assign imem_enable  = !stall;
    assign imem_address = pc;

    always_ff @(posedge clk)
    begin
        if (reset || redirect.taken)
        begin
            to_decode.valid <= 1'b0;
            to_decode.instr <= `CORE_NOP;
        end
        else if (!stall)
        begin
            to_decode.valid <= 1'b1;
            to_decode.pc    <= pc;
            to_decode.instr <= imem_data;
        end
    end

endmodule

// File: hdl/register_file.sv
`include "core_macros.svh"

module register_file
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic [$clog2(`CORE_REG_COUNT)-1:0] read_index_1,
    input  logic [$clog2(`CORE_REG_COUNT)-1:0] read_index_2,
    output logic [`CORE_XLEN-1:0]              read_data_1,
    output logic [`CORE_XLEN-1:0]              read_data_2,
    input  core_pkg::reg_write_t               write
);

    // x0 has no storage
    logic [`CORE_XLEN-1:0] registers [1:`CORE_REG_COUNT-1];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 1; i < `CORE_REG_COUNT; i++)
                registers[i] <= '0;
        end
        else if (write.enable && write.index != '0)
        begin
            registers[write.index] <= write.data;
        end
    end

    // Same-cycle writes reach decode through the write-back forward path
    assign read_data_1 = (read_index_1 == '0) ? '0 : registers[read_index_1];
    assign read_data_2 = (read_index_2 == '0) ? '0 : registers[read_index_2];

endmodule

// File: hdl/result_stage.sv
`include "core_macros.svh"

module result_stage
(
    input  logic                          clk,
    input  logic                          reset,
    input  core_pkg::execute_to_result_t  from_execute,
    output logic                          dmem_enable,
    output logic                          dmem_write,
    output logic [`CORE_XLEN-1:0]         dmem_address,
    output logic [`CORE_XLEN-1:0]         dmem_wdata,
    input  logic [`CORE_XLEN-1:0]         dmem_rdata,
    output core_pkg::reg_write_t          memory_write,
    output core_pkg::reg_write_t          writeback_write
);

    // --------------------
    // Memory stage
    // --------------------

    assign dmem_enable  = from_execute.valid && (from_execute.is_load || from_execute.is_store);
    assign dmem_write   = from_execute.valid && from_execute.is_store;
    assign dmem_address = from_execute.address;
    assign dmem_wdata   = from_execute.store_data;

    // Memory answers in the same cycle, so load data is final here
    assign memory_write.enable = from_execute.valid && from_execute.reg_write;
    assign memory_write.index  = from_execute.rd;
    assign memory_write.data   = from_execute.is_load ? dmem_rdata : from_execute.result;
    assign memory_write.ready  = 1'b1;

    // --------------------
    // Write-back stage
    // --------------------

    always_ff @(posedge clk)
    begin
        if (reset)
            writeback_write.enable <= 1'b0;
        else
            writeback_write.enable <= memory_write.enable;
        writeback_write.index <= memory_write.index;
        writeback_write.data  <= memory_write.data;
        writeback_write.ready <= memory_write.ready;
    end

endmodule

// File: hdl/riscv_core.sv
`include "core_macros.svh"

module riscv_core
(
    input  logic                  clk,
    input  logic                  reset,
    output logic                  imem_enable,
    output logic [`CORE_XLEN-1:0] imem_address,
    input  logic [`CORE_XLEN-1:0] imem_data,
    output logic                  dmem_enable,
    output logic                  dmem_write,
    output logic [`CORE_XLEN-1:0] dmem_address,
    output logic [`CORE_XLEN-1:0] dmem_wdata,
    input  logic [`CORE_XLEN-1:0] dmem_rdata
);

    core_pkg::fetch_to_decode_t   fetch_to_decode;
    core_pkg::decode_to_execute_t decode_to_execute;
    core_pkg::execute_to_result_t execute_to_result;
    core_pkg::redirect_t          redirect;
    core_pkg::reg_write_t         execute_write;
    core_pkg::reg_write_t         memory_write;
    core_pkg::reg_write_t         writeback_write;
    logic                         stall;

    fetch_stage fetch_stage
    (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .redirect     (redirect),
        .imem_enable  (imem_enable),
        .imem_address (imem_address),
        .imem_data    (imem_data),
        .to_decode    (fetch_to_decode)
    );

    decode_stage decode_stage
    (
        .clk             (clk),
        .reset           (reset),
        .from_fetch      (fetch_to_decode),
        .redirect        (redirect),
        .execute_write   (execute_write),
        .memory_write    (memory_write),
        .writeback_write (writeback_write),
        .stall           (stall),
        .to_execute      (decode_to_execute)
    );

    execute_stage execute_stage
    (
        .clk           (clk),
        .reset         (reset),
        .from_decode   (decode_to_execute),
        .redirect      (redirect),
        .execute_write (execute_write),
        .to_result     (execute_to_result)
    );

    result_stage result_stage
    (
        .clk             (clk),
        .reset           (reset),
        .from_execute    (execute_to_result),
        .dmem_enable     (dmem_enable),
        .dmem_write      (dmem_write),
        .dmem_address    (dmem_address),
        .dmem_wdata      (dmem_wdata),
        .dmem_rdata      (dmem_rdata),
        .memory_write    (memory_write),
        .writeback_write (writeback_write)
    );

endmodule

// File: sim/core_checker.sv
`include "core_macros.svh"

module core_checker
(
    input logic                  clk,
    input logic                  reset,
    input logic                  imem_enable,
    input logic [`CORE_XLEN-1:0] imem_address,
    input logic                  dmem_enable,
    input logic                  dmem_write,
    input logic [`CORE_XLEN-1:0] dmem_address,
    input logic [`CORE_XLEN-1:0] dmem_wdata
);

    timeunit 1ns;
    timeprecision 1ns;

    // Last program word is a JAL to itself, two wrong-path fetches may follow it
    localparam logic [`CORE_XLEN-1:0] last_word  = 32'd80;
    localparam logic [`CORE_XLEN-1:0] fetch_max  = last_word + 32'd8;
    localparam logic [`CORE_XLEN-1:0] jal_link   = 32'd68 + 32'd4;

    int failure_count = 0;

    // Register values the program leaves behind at each store
    function automatic logic [`CORE_XLEN-1:0] expected_store(input logic [`CORE_XLEN-1:0] address);
        case (address)
            32'h100: return 32'd5 + (32'd5 + 32'd7);
            32'h104: return (32'h12345 << 12) + 32'h678;
            32'h108: return 32'd12;
            32'h10c: return 32'd12 + 32'd1;
            // x7 is only written on the flushed path
            32'h110: return 32'd0;
            32'h114: return jal_link;
            default: return 32'd17;
        endcase
    endfunction

    function automatic logic known_store(input logic [`CORE_XLEN-1:0] address);
        return address inside {32'h100, 32'h104, 32'h108, 32'h10c, 32'h110, 32'h114, 32'h118};
    endfunction

    // --------------------
    // Reset state
    // --------------------

    reset_fetch_address: assert property (@(posedge clk)
        $fell(reset) |-> imem_address == `CORE_RESET_ADDRESS)
    else
    begin
        failure_count++;
        $error("** Error at %0t ns: imem_address expected 0x%h, got 0x%h",
               $time, `CORE_RESET_ADDRESS, $sampled(imem_address));
    end

    // Fetch starts in the first cycle after reset
    reset_fetch_enable: assert property (@(posedge clk) $fell(reset) |-> imem_enable)
    else
    begin
        failure_count++;
        $error("** Error at %0t ns: imem_enable expected 1, got %b",
               $time, $sampled(imem_enable));
    end

    reset_data_idle: assert property (@(posedge clk) $fell(reset) |-> !dmem_enable)
    else
    begin
        failure_count++;
        $error("** Error at %0t ns: dmem_enable expected 0, got %b",
               $time, $sampled(dmem_enable));
    end

    // --------------------
    // Stores
    // --------------------

    store_address: assert property (@(posedge clk) disable iff (reset)
        dmem_enable && dmem_write |-> known_store(dmem_address))
    else
    begin
        failure_count++;
        $error("** Error at %0t ns: dmem_address expected one of 0x100 to 0x118, got 0x%h",
               $time, $sampled(dmem_address));
    end

    store_data: assert property (@(posedge clk) disable iff (reset)
        dmem_enable && dmem_write && known_store(dmem_address) |->
            dmem_wdata == expected_store(dmem_address))
    else
    begin
        failure_count++;
        $error("** Error at %0t ns: dmem_wdata expected 0x%h, got 0x%h", $time,
               expected_store($sampled(dmem_address)), $sampled(dmem_wdata));
    end

    // --------------------
    // Fetch
    // --------------------

    fetch_range: assert property (@(posedge clk) disable iff (reset)
        imem_enable |-> imem_address <= fetch_max && imem_address[1:0] == 2'b00)
    else
    begin
        failure_count++;
        $error("** Error at %0t ns: imem_address expected an aligned word up to 0x%h, got 0x%h",
               $time, fetch_max, $sampled(imem_address));
    end

endmodule

bind riscv_core core_checker core_checker_i (.*);

// File: sim/core_tb.sv
`include "core_macros.svh"

module core_tb;

    timeunit 1ns;
    timeprecision 1ns;

    // 30 instructions at up to 3 cycles each, pipeline depth 5, margin for reset
    localparam int cycle_limit = 30 * 3 + 5 + 105;
    localparam int store_tests = 6;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  imem_enable;
    logic [`CORE_XLEN-1:0] imem_address;
    logic [`CORE_XLEN-1:0] imem_data;
    logic                  dmem_enable;
    logic                  dmem_write;
    logic [`CORE_XLEN-1:0] dmem_address;
    logic [`CORE_XLEN-1:0] dmem_wdata;
    logic [`CORE_XLEN-1:0] dmem_rdata;

    logic [`CORE_XLEN-1:0] imem [0:31];
    logic [`CORE_XLEN-1:0] dmem [0:63];
    int                    cycle_count = 0;
    bit                    seen [store_tests];

    string                 test_name [store_tests] = '{"arithmetic forwarding",
        "lui and immediates", "load-use stall", "branch flush", "jump and link",
        "branch not taken"};
    logic [`CORE_XLEN-1:0] test_address [store_tests] = '{32'h100, 32'h104,
        32'h10c, 32'h110, 32'h114, 32'h118};

    riscv_core dut_i
    (
        .clk          (clk),
        .reset        (reset),
        .imem_enable  (imem_enable),
        .imem_address (imem_address),
        .imem_data    (imem_data),
        .dmem_enable  (dmem_enable),
        .dmem_write   (dmem_write),
        .dmem_address (dmem_address),
        .dmem_wdata   (dmem_wdata),
        .dmem_rdata   (dmem_rdata)
    );

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
    end

    // --------------------
    // Instruction encoding
    // --------------------

    function automatic logic [31:0] addi(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] add(input logic [4:0] rd, rs1, rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] lw(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw(input logic [4:0] rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch(input logic [2:0] funct3, input logic [4:0] rs1, rs2,
                                           input logic [12:0] offset);
        return {offset[12], offset[10:5], rs2, rs1, funct3, offset[4:1], offset[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] offset);
        return {offset[20], offset[10:1], offset[11], offset[19:12], rd, 7'b1101111};
    endfunction

    // --------------------
    // Memory models
    // --------------------

    task automatic load_program();
        // Unused words hold ADDI x0, x0 with their own address as a harmless marker
        for (int i = 0; i < 32; i++)
            imem[i] = addi(5'd0, 5'd0, 12'(i * 4));
        imem[0]  = addi(5'd1, 5'd0, 12'd5);
        imem[1]  = addi(5'd2, 5'd1, 12'd7);
        imem[2]  = add(5'd3, 5'd1, 5'd2);
        imem[3]  = sw(5'd3, 5'd0, 12'h100);
        imem[4]  = lui(5'd4, 20'h12345);
        imem[5]  = addi(5'd4, 5'd4, 12'h678);
        imem[6]  = sw(5'd4, 5'd0, 12'h104);
        imem[7]  = sw(5'd2, 5'd0, 12'h108);
        imem[8]  = lw(5'd5, 5'd0, 12'h108);
        imem[9]  = addi(5'd6, 5'd5, 12'd1);
        imem[10] = sw(5'd6, 5'd0, 12'h10c);
        imem[11] = branch(3'b000, 5'd1, 5'd1, 13'd12);
        imem[12] = addi(5'd7, 5'd0, 12'd99);
        imem[13] = addi(5'd7, 5'd7, 12'd1);
        imem[14] = sw(5'd7, 5'd0, 12'h110);
        imem[15] = branch(3'b001, 5'd1, 5'd1, 13'd8);
        imem[16] = sw(5'd3, 5'd0, 12'h118);
        imem[17] = jal(5'd8, 21'd8);
        imem[18] = addi(5'd8, 5'd0, 12'd1);
        imem[19] = sw(5'd8, 5'd0, 12'h114);
        imem[20] = jal(5'd0, 21'd0);
    endtask

    task automatic fill_data();
        for (int i = 0; i < 64; i++)
            dmem[i] = 32'hdada_0000 | (i << 2);
    endtask

    assign imem_data  = imem[imem_address[6:2]];
    assign dmem_rdata = dmem[dmem_address[7:2]];

    always @(posedge clk)
    begin
        if (dmem_enable && dmem_write)
            dmem[dmem_address[7:2]] <= dmem_wdata;
    end

    // --------------------
    // Reporting
    // --------------------

    always @(posedge clk)
    begin
        if (!reset && dmem_enable && dmem_write)
        begin
            for (int t = 0; t < store_tests; t++)
            begin
                if (dmem_address == test_address[t] && !seen[t])
                begin
                    seen[t] <= 1'b1;
                    $display("test %s: store of 0x%h to 0x%h at %0t ns",
                             test_name[t], dmem_wdata, dmem_address, $time);
                end
            end
        end
    end

    function automatic bit all_seen();
        for (int t = 0; t < store_tests; t++)
            if (!seen[t])
                return 1'b0;
        return 1'b1;
    endfunction

    initial
    begin
        int missing;
        int failures;
        missing = 0;
        reset   = 1'b1;
        load_program();
        fill_data();
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        $display("test reset state: checked in the first cycle after reset at %0t ns", $time);
        while (!all_seen() && cycle_count < cycle_limit)
            @(posedge clk);
        // Let the checks of the last store finish
        repeat (2) @(posedge clk);
        for (int t = 0; t < store_tests; t++)
        begin
            if (!seen[t])
            begin
                missing++;
                $display("test %s: the store to 0x%h never appeared within %0d cycles",
                         test_name[t], test_address[t], cycle_limit);
            end
        end
        failures = dut_i.core_checker_i.failure_count;
        $display("tests: %0d, missing: %0d, assertion failures: %0d",
                 store_tests + 1, missing, failures);
        if (missing == 0 && failures == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule
